/* rvCore.f */
+incdir+test
design/rvIsaPkg.sv
design/rvCtrlPkg.sv
design/rvCoreIf.sv
design/fetchStage.sv
design/controlUnit.sv
design/executeStage.sv
design/memStage.sv
design/rvCore.sv
test/rvCoreTb.sv

/* test/rvCoreProgram.svh */
`ifndef rvCoreProgramSvh
`define rvCoreProgramSvh

// columns: instruction word, retireEn, retireRd, retireData, next pc
// row n sits at resetPc + 4n, so the table starts at 0x100
task automatic loadProgram();
    // alu, x1 = 5 and x2 = -3
    addStep(iType(12'h005, 0, 3'b000, 1, rvIsaPkg::opI), 1, 1, 32'h0000_0005, 32'h104);
    addStep(iType(12'hFFD, 0, 3'b000, 2, rvIsaPkg::opI), 1, 2, 32'hFFFF_FFFD, 32'h108);
    addStep(rType(7'h00, 2, 1, 3'b000, 3), 1, 3, 32'h0000_0002, 32'h10C);    // add
    addStep(rType(7'h20, 2, 1, 3'b000, 4), 1, 4, 32'h0000_0008, 32'h110);    // sub
    addStep(rType(7'h00, 1, 2, 3'b010, 5), 1, 5, 32'h0000_0001, 32'h114);    // slt -3 < 5
    addStep(rType(7'h00, 1, 2, 3'b011, 6), 1, 6, 32'h0000_0000, 32'h118);    // sltu
    addStep(rType(7'h00, 2, 1, 3'b100, 7), 1, 7, 32'hFFFF_FFF8, 32'h11C);    // xor
    addStep(rType(7'h00, 2, 1, 3'b110, 8), 1, 8, 32'hFFFF_FFFD, 32'h120);    // or
    addStep(rType(7'h00, 2, 1, 3'b111, 9), 1, 9, 32'h0000_0005, 32'h124);    // and
    addStep(iType(12'h004, 1, 3'b001, 10, rvIsaPkg::opI), 1, 10, 32'h0000_0050, 32'h128);
    addStep(iType(12'h401, 2, 3'b101, 11, rvIsaPkg::opI), 1, 11, 32'hFFFF_FFFE, 32'h12C);
    addStep(rType(7'h00, 1, 2, 3'b101, 12), 1, 12, 32'h07FF_FFFF, 32'h130);  // srl by 5
    addStep(iType(12'h007, 1, 3'b000, 0, rvIsaPkg::opI), 1, 0, 32'h0000_000C, 32'h134);
    addStep(rType(7'h00, 0, 0, 3'b000, 13), 1, 13, 32'h0000_0000, 32'h138);  // x0 still zero
    // upper immediates
    addStep(uType(20'h12345, 14, rvIsaPkg::opLui), 1, 14, 32'h1234_5000, 32'h13C);
    addStep(uType(20'h00001, 15, rvIsaPkg::opAuipc), 1, 15, 32'h0000_113C, 32'h140);
    // memory, base x16 = 0x80 and x17 = 0x89ABCDEF
    addStep(iType(12'h080, 0, 3'b000, 16, rvIsaPkg::opI), 1, 16, 32'h0000_0080, 32'h144);
    addStep(uType(20'h89ABD, 17, rvIsaPkg::opLui), 1, 17, 32'h89AB_D000, 32'h148);
    addStep(iType(12'hDEF, 17, 3'b000, 17, rvIsaPkg::opI), 1, 17, 32'h89AB_CDEF, 32'h14C);
    addStep(sType(12'h000, 17, 16, rvIsaPkg::f3Word), 0, 0, 32'h0, 32'h150);
    addStep(iType(12'h000, 16, rvIsaPkg::f3Word, 18, rvIsaPkg::opLoad), 1, 18, 32'h89AB_CDEF,
            32'h154);
    addStep(iType(12'h001, 16, rvIsaPkg::f3Byte, 19, rvIsaPkg::opLoad), 1, 19, 32'hFFFF_FFCD,
            32'h158);
    addStep(iType(12'h003, 16, rvIsaPkg::f3ByteU, 20, rvIsaPkg::opLoad), 1, 20, 32'h0000_0089,
            32'h15C);
    addStep(iType(12'h002, 16, rvIsaPkg::f3Half, 21, rvIsaPkg::opLoad), 1, 21, 32'hFFFF_89AB,
            32'h160);
    addStep(iType(12'h000, 16, rvIsaPkg::f3HalfU, 22, rvIsaPkg::opLoad), 1, 22, 32'h0000_CDEF,
            32'h164);
    addStep(sType(12'h002, 1, 16, rvIsaPkg::f3Byte), 0, 0, 32'h0, 32'h168);  // word 8905CDEF
    addStep(sType(12'h000, 2, 16, rvIsaPkg::f3Half), 0, 0, 32'h0, 32'h16C);  // word 8905FFFD
    addStep(iType(12'h000, 16, rvIsaPkg::f3Word, 23, rvIsaPkg::opLoad), 1, 23, 32'h8905_FFFD,
            32'h170);
    // branches, taken ones hop over a skipped slot
    addStep(bType(8, 1, 1, rvIsaPkg::f3Beq), 0, 0, 32'h0, 32'h178);
    addSkip();
    addStep(bType(8, 2, 1, rvIsaPkg::f3Beq), 0, 0, 32'h0, 32'h17C);
    addStep(bType(8, 2, 1, rvIsaPkg::f3Bne), 0, 0, 32'h0, 32'h184);
    addSkip();
    addStep(bType(8, 1, 1, rvIsaPkg::f3Bne), 0, 0, 32'h0, 32'h188);
    addStep(bType(8, 1, 2, rvIsaPkg::f3Blt), 0, 0, 32'h0, 32'h190);   // -3 < 5
    addSkip();
    addStep(bType(8, 2, 1, rvIsaPkg::f3Blt), 0, 0, 32'h0, 32'h194);
    addStep(bType(8, 2, 1, rvIsaPkg::f3Bge), 0, 0, 32'h0, 32'h19C);
    addSkip();
    addStep(bType(8, 1, 2, rvIsaPkg::f3Bge), 0, 0, 32'h0, 32'h1A0);
    addStep(bType(8, 2, 1, rvIsaPkg::f3Bltu), 0, 0, 32'h0, 32'h1A8);  // 5 below 0xFFFFFFFD
    addSkip();
    addStep(bType(8, 1, 2, rvIsaPkg::f3Bltu), 0, 0, 32'h0, 32'h1AC);
    addStep(bType(8, 1, 2, rvIsaPkg::f3Bgeu), 0, 0, 32'h0, 32'h1B4);
    addSkip();
    addStep(bType(8, 2, 1, rvIsaPkg::f3Bgeu), 0, 0, 32'h0, 32'h1B8);
    // jumps
    addStep(jType(12, 25), 1, 25, 32'h0000_01BC, 32'h1C4);
    addSkip();
    addSkip();
    addStep(iType(12'h1D5, 0, 3'b000, 26, rvIsaPkg::opI), 1, 26, 32'h0000_01D5, 32'h1C8);
    addStep(iType(12'h000, 26, 3'b000, 27, rvIsaPkg::opJalr), 1, 27, 32'h0000_01CC, 32'h1D4);
    addSkip();
    addSkip();
    addStep(iType(12'h004, 27, 3'b000, 28, rvIsaPkg::opI), 1, 28, 32'h0000_01D0, 32'h1D8);
endtask

`endif

/* test/rvCoreTb.sv */
`default_nettype none

module rvCoreTb;

    localparam logic [31:0] resetPc    = 32'h0000_0100;
    localparam int          halfPeriod = 10;
    localparam int          maxSteps   = 64;
    localparam int          randPairs  = 16;            // addi and add per pair

    logic              clk;
    logic              rstN;
    logic [31:0]       instr;
    logic [31:0]       pc;
    logic              retireEn;
    rvIsaPkg::regAddrT retireRd;
    logic [31:0]       retireData;

    logic [31:0] stepInstr [maxSteps];                  // row n is fetched from resetPc + 4n
    logic        stepEn    [maxSteps];
    logic [4:0]  stepRd    [maxSteps];
    logic [31:0] stepData  [maxSteps];
    logic [31:0] stepNext  [maxSteps];
    int          numSteps;
    int          errors;
    int          checks;
    int          cycleCount;
    int          cycleLimit;
    integer      seed;

    rvCore #(
        .resetPc  (resetPc),
        .dmemWords(256)
    ) dut0 (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .pc        (pc),
        .retireEn  (retireEn),
        .retireRd  (retireRd),
        .retireData(retireData)
    );

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvIsaPkg::opR};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};                  // alu imm, loads, jalr
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rvIsaPkg::opStore};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvIsaPkg::opBranch};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::opJal};
    endfunction

    task automatic addStep(input logic [31:0] word, input logic en, input logic [4:0] rd,
                           input logic [31:0] data, input logic [31:0] next);
        stepInstr[numSteps] = word;
        stepEn[numSteps]    = en;
        stepRd[numSteps]    = rd;
        stepData[numSteps]  = data;
        stepNext[numSteps]  = next;
        numSteps            = numSteps + 1;
    endtask

    // slot jumped over by a branch or jump; fetching it retires x31 and fails
    task automatic addSkip();
        addStep(iType(12'h7FF, 0, 3'b000, 31, rvIsaPkg::opI), 0, 0, 32'h0, 32'h0);
    endtask

    `include "rvCoreProgram.svh"

    function automatic int rowOf(input logic [31:0] addr);
        if (addr < resetPc || addr[1:0] != 2'b00) begin
            return -1;
        end
        if ((addr - resetPc) / 4 >= numSteps) begin
            return -1;
        end
        return (addr - resetPc) / 4;
    endfunction

    // called right after a falling edge
    task automatic runStep(input logic [31:0] word, input logic expEn, input logic [4:0] expRd,
                           input logic [31:0] expData, input logic [31:0] expNext);
        logic [31:0] stepPc;
        stepPc = pc;
        instr  = word;
        #(halfPeriod - 1);                              // settled, edge not yet seen
        checks = checks + 2;
        if (retireEn !== expEn) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: pc %h retireEn %b, expected %b",
                     $time, stepPc, retireEn, expEn);
        end
        if (expEn && (retireRd !== expRd || retireData !== expData)) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: pc %h wrote x%0d = %h, expected x%0d = %h",
                     $time, stepPc, retireRd, retireData, expRd, expData);
        end
        @(posedge clk);
        #1;
        if (pc !== expNext) begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: after pc %h next pc %h, expected %h",
                     $time, stepPc, pc, expNext);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int          row;
        logic        done;
        logic [31:0] randWord;
        logic [11:0] imm;
        logic [31:0] immExt;
        logic [31:0] acc;
        rstN       = 1'b0;
        instr      = iType(12'h005, 0, 3'b000, 1, rvIsaPkg::opI);  // would write x1 if not gated
        errors     = 0;
        checks     = 0;
        cycleCount = 0;
        numSteps   = 0;
        seed       = 4632;
        loadProgram();
        cycleLimit = numSteps + 2 * randPairs + 20;

        repeat (3) begin
            @(negedge clk);
            checks = checks + 1;
            if (pc !== resetPc || retireEn !== 1'b0) begin
                errors = errors + 1;
                $display("CHECK FAILED at %0t: in reset pc %h retireEn %b", $time, pc, retireEn);
            end
        end
        rstN = 1'b1;                                    // released on a falling edge

        done = 1'b0;
        while (!done) begin
            row = rowOf(pc);
            if (row < 0) begin
                errors = errors + 1;
                $display("program flow left the table at pc %h", pc);
                done = 1'b1;
            end else begin
                runStep(stepInstr[row], stepEn[row], stepRd[row], stepData[row], stepNext[row]);
                @(negedge clk);
                done = (pc == resetPc + 4 * numSteps);
            end
        end

        acc = 32'h0;                                    // x6 was cleared by the sltu row
        repeat (randPairs) begin
            randWord = $random(seed);
            imm      = randWord[11:0];
            immExt   = {{20{imm[11]}}, imm};
            acc      = acc + immExt;
            runStep(iType(imm, 0, 3'b000, 5, rvIsaPkg::opI), 1'b1, 5, immExt, pc + 4);
            @(negedge clk);
            runStep(rType(7'h00, 5, 6, 3'b000, 6), 1'b1, 6, acc, pc + 4);  // x6 += x5
            @(negedge clk);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/rvCore.sv */
`default_nettype none

module rvCore #(
    parameter logic [rvIsaPkg::xlen-1:0] resetPc   = '0,
    parameter int                        dmemWords = 256
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [31:0]               instr,        // from the external imem
    output logic [rvIsaPkg::xlen-1:0] pc,
    output logic                      retireEn,     // register write this cycle
    output rvIsaPkg::regAddrT         retireRd,
    output logic [rvIsaPkg::xlen-1:0] retireData
);

    pcIf  pcBus ();
    memIf memBus ();

    fetchStage #(
        .resetPc(resetPc)
    ) fetch0 (
        .clk  (clk),
        .rstN (rstN),
        .pcBus(pcBus)
    );

    executeStage exec0 (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instr),
        .pcBus   (pcBus),
        .memBus  (memBus),
        .retireEn(retireEn),
        .retireRd(retireRd)
    );

    memStage #(
        .dmemWords(dmemWords)
    ) mem0 (
        .clk   (clk),
        .rstN  (rstN),
        .memBus(memBus)
    );

    assign pc         = pcBus.pc;
    assign retireData = memBus.result;              // same value the regfile takes

endmodule

`default_nettype wire

/* design/memStage.sv */
`default_nettype none

module memStage #(
    parameter int dmemWords = 256                   // words of data memory
) (
    input  logic clk,
    input  logic rstN,
    memIf.mem    memBus
);

    localparam int xlen = rvIsaPkg::xlen;
    localparam int idxW = $clog2(dmemWords);

    logic [xlen-1:0] dmem [dmemWords];
    logic [idxW-1:0] wordIdx;
    logic [1:0]      byteOff;                       // lane within the word
    logic [xlen-1:0] laneWord, loadData;
    logic            misaligned;

    assign wordIdx  = memBus.aluResult[idxW+1:2];
    assign byteOff  = memBus.aluResult[1:0];
    assign laneWord = dmem[wordIdx] >> {byteOff, 3'b000};  // addressed lane to bit 0

    always_ff @(posedge clk) begin
        if (memBus.memWrite && rstN) begin
            case (memBus.funct3)
                rvIsaPkg::f3Byte: dmem[wordIdx][{byteOff, 3'b000} +: 8] <= memBus.writeData[7:0];
                rvIsaPkg::f3Half: dmem[wordIdx][{byteOff[1], 4'b0000} +: 16] <=
                                  memBus.writeData[15:0];
                default:          dmem[wordIdx] <= memBus.writeData;  // sw
            endcase
        end
    end

    always_comb begin
        case (memBus.funct3)
            rvIsaPkg::f3Byte:  loadData = {{24{laneWord[7]}}, laneWord[7:0]};    // lb
            rvIsaPkg::f3Half:  loadData = {{16{laneWord[15]}}, laneWord[15:0]};  // lh
            rvIsaPkg::f3ByteU: loadData = {24'b0, laneWord[7:0]};                // lbu
            rvIsaPkg::f3HalfU: loadData = {16'b0, laneWord[15:0]};               // lhu
            default:           loadData = laneWord;                              // lw
        endcase
    end

    always_comb begin
        case (memBus.resultSrc)
            rvCtrlPkg::resLoad:     memBus.result = loadData;
            rvCtrlPkg::resPcPlus4:  memBus.result = memBus.pcPlus4;
            rvCtrlPkg::resPcTarget: memBus.result = memBus.pcTarget;
            default:                memBus.result = memBus.aluResult;
        endcase
    end

    // funct3[1:0] carries the size for both signed and unsigned loads
    assign misaligned = (memBus.funct3[1:0] == rvIsaPkg::f3Half[1:0] && byteOff[0]) ||
                        (memBus.funct3 == rvIsaPkg::f3Word && byteOff != 2'b00);

    alignedAccess: assert property (
        @(posedge clk) disable iff (!rstN)
        (memBus.memWrite || memBus.resultSrc == rvCtrlPkg::resLoad) |-> !misaligned
    ) else $error("misaligned access at %h", memBus.aluResult);

endmodule

`default_nettype wire

/* design/executeStage.sv */
`default_nettype none

module executeStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic [31:0]       instr,
    pcIf.exec                 pcBus,
    memIf.exec                memBus,
    output logic              retireEn,
    output rvIsaPkg::regAddrT retireRd
);

    localparam int xlen = rvIsaPkg::xlen;

    rvCtrlPkg::pcSrcT     pcSrc;
    rvCtrlPkg::resultSrcT resultSrc;
    rvCtrlPkg::immSrcT    immSrc;
    rvCtrlPkg::aluOpT     aluOp;
    rvCtrlPkg::aluCtrlT   aluCtrl;
    logic                 memWrite, aluSrc, regWrite;
    logic                 zeroFlag, negativeFlag, unsignedLess;
    rvIsaPkg::regAddrT    rs1, rs2, rd;
    logic [2:0]           funct3;
    logic                 funct7b5;                 // sub and sra select
    logic [xlen-1:0]      regFile [32];             // entry 0 is never written
    logic [xlen-1:0]      rd1, rd2, immExt, srcB, aluResult;
    logic [xlen:0]        diff;                     // extra bit gives the unsigned borrow
    logic                 overflow;

    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    controlUnit ctrl0 (
        .opcode      (instr[6:0]),
        .funct3      (funct3),
        .zeroFlag    (zeroFlag),
        .negativeFlag(negativeFlag),
        .unsignedLess(unsignedLess),
        .pcSrc       (pcSrc),
        .resultSrc   (resultSrc),
        .memWrite    (memWrite),
        .aluSrc      (aluSrc),
        .immSrc      (immSrc),
        .regWrite    (regWrite),
        .aluOp       (aluOp)
    );

    assign rd1 = (rs1 == '0) ? '0 : regFile[rs1];   // x0 reads as zero
    assign rd2 = (rs2 == '0) ? '0 : regFile[rs2];

    assign retireEn = regWrite && rstN;             // nothing retires in reset
    assign retireRd = rd;

    always_ff @(posedge clk) begin
        if (retireEn && rd != '0) begin
            regFile[rd] <= memBus.result;           // alu, load or link value
        end
    end

    always_comb begin
        case (immSrc)
            rvCtrlPkg::immS: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvCtrlPkg::immB: immExt = {{20{instr[31]}}, instr[7], instr[30:25],
                                       instr[11:8], 1'b0};
            rvCtrlPkg::immU: immExt = {instr[31:12], 12'b0};
            rvCtrlPkg::immJ: immExt = {{12{instr[31]}}, instr[19:12], instr[20],
                                       instr[30:21], 1'b0};
            default:         immExt = {{20{instr[31]}}, instr[31:20]};  // I format
        endcase
    end

    always_comb begin
        case (aluOp)
            rvCtrlPkg::aluOpR, rvCtrlPkg::aluOpI: begin
                case (funct3)
                    3'b000:  aluCtrl = (aluOp == rvCtrlPkg::aluOpR && funct7b5) ?
                                       rvCtrlPkg::aluSub : rvCtrlPkg::aluAdd;  // no subi
                    3'b001:  aluCtrl = rvCtrlPkg::aluSll;
                    3'b010:  aluCtrl = rvCtrlPkg::aluSlt;
                    3'b011:  aluCtrl = rvCtrlPkg::aluSltu;
                    3'b100:  aluCtrl = rvCtrlPkg::aluXor;
                    3'b101:  aluCtrl = funct7b5 ? rvCtrlPkg::aluSra : rvCtrlPkg::aluSrl;
                    3'b110:  aluCtrl = rvCtrlPkg::aluOr;
                    default: aluCtrl = rvCtrlPkg::aluAnd;
                endcase
            end
            rvCtrlPkg::aluOpBranch: aluCtrl = rvCtrlPkg::aluSub;   // compare via flags
            rvCtrlPkg::aluOpLui:    aluCtrl = rvCtrlPkg::aluPassB;
            default:                aluCtrl = rvCtrlPkg::aluAdd;   // addresses, jalr
        endcase
    end

    assign srcB         = aluSrc ? immExt : rd2;
    assign diff         = {1'b0, rd1} - {1'b0, srcB};
    assign overflow     = (rd1[xlen-1] != srcB[xlen-1]) && (diff[xlen-1] != rd1[xlen-1]);
    assign zeroFlag     = (diff[xlen-1:0] == '0);
    assign negativeFlag = diff[xlen-1] ^ overflow;  // signed less than
    assign unsignedLess = diff[xlen];               // borrow out

    always_comb begin
        case (aluCtrl)
            rvCtrlPkg::aluSub:   aluResult = diff[xlen-1:0];
            rvCtrlPkg::aluSll:   aluResult = rd1 << srcB[4:0];
            rvCtrlPkg::aluSlt:   aluResult = xlen'(negativeFlag);
            rvCtrlPkg::aluSltu:  aluResult = xlen'(unsignedLess);
            rvCtrlPkg::aluXor:   aluResult = rd1 ^ srcB;
            rvCtrlPkg::aluSrl:   aluResult = rd1 >> srcB[4:0];
            rvCtrlPkg::aluSra:   aluResult = $signed(rd1) >>> srcB[4:0];
            rvCtrlPkg::aluOr:    aluResult = rd1 | srcB;
            rvCtrlPkg::aluAnd:   aluResult = rd1 & srcB;
            rvCtrlPkg::aluPassB: aluResult = srcB;
            default:             aluResult = rd1 + srcB;
        endcase
    end

    assign pcBus.pcSrc     = pcSrc;
    assign pcBus.pcTarget  = pcBus.pc + immExt;                  // branch, jal, auipc
    assign pcBus.aluResult = {aluResult[xlen-1:1], 1'b0};        // jalr drops bit 0

    assign memBus.aluResult = aluResult;
    assign memBus.writeData = rd2;
    assign memBus.memWrite  = memWrite;
    assign memBus.resultSrc = resultSrc;
    assign memBus.funct3    = funct3;
    assign memBus.pcPlus4   = pcBus.pcPlus4;
    assign memBus.pcTarget  = pcBus.pcTarget;

endmodule

`default_nettype wire

/* design/controlUnit.sv */
`default_nettype none

module controlUnit (
    input  logic [6:0]           opcode,        // instr[6:0]
    input  logic [2:0]           funct3,        // branch condition
    input  logic                 zeroFlag,      // rs1 == rs2
    input  logic                 negativeFlag,  // rs1 < rs2 signed
    input  logic                 unsignedLess,  // rs1 < rs2 unsigned
    output rvCtrlPkg::pcSrcT     pcSrc,
    output rvCtrlPkg::resultSrcT resultSrc,
    output logic                 memWrite,
    output logic                 aluSrc,        // 1 selects the immediate
    output rvCtrlPkg::immSrcT    immSrc,
    output logic                 regWrite,
    output rvCtrlPkg::aluOpT     aluOp          // class for the alu decoder
);

    always_comb begin
        case (opcode)
            rvIsaPkg::opR:      aluOp = rvCtrlPkg::aluOpR;
            rvIsaPkg::opI:      aluOp = rvCtrlPkg::aluOpI;
            rvIsaPkg::opLoad:   aluOp = rvCtrlPkg::aluOpLoad;
            rvIsaPkg::opStore:  aluOp = rvCtrlPkg::aluOpStore;
            rvIsaPkg::opBranch: aluOp = rvCtrlPkg::aluOpBranch;
            rvIsaPkg::opJal:    aluOp = rvCtrlPkg::aluOpJump;
            rvIsaPkg::opJalr:   aluOp = rvCtrlPkg::aluOpJump;  // rs1 + imm in the alu
            rvIsaPkg::opLui:    aluOp = rvCtrlPkg::aluOpLui;
            rvIsaPkg::opAuipc:  aluOp = rvCtrlPkg::aluOpAuipc;
            default:            aluOp = rvCtrlPkg::aluOpR;
        endcase

        case (opcode)
            rvIsaPkg::opLoad:  resultSrc = rvCtrlPkg::resLoad;
            rvIsaPkg::opJal,
            rvIsaPkg::opJalr:  resultSrc = rvCtrlPkg::resPcPlus4;   // link register value
            rvIsaPkg::opAuipc: resultSrc = rvCtrlPkg::resPcTarget;  // pc + upper imm
            default:           resultSrc = rvCtrlPkg::resAlu;       // lui goes through passB
        endcase

        memWrite = (opcode == rvIsaPkg::opStore);

        case (opcode)
            rvIsaPkg::opR,
            rvIsaPkg::opBranch: aluSrc = 1'b0;      // two register operands
            default:            aluSrc = 1'b1;
        endcase

        case (opcode)
            rvIsaPkg::opStore:  immSrc = rvCtrlPkg::immS;
            rvIsaPkg::opBranch: immSrc = rvCtrlPkg::immB;
            rvIsaPkg::opLui,
            rvIsaPkg::opAuipc:  immSrc = rvCtrlPkg::immU;
            rvIsaPkg::opJal:    immSrc = rvCtrlPkg::immJ;
            default:            immSrc = rvCtrlPkg::immI;  // alu imm, loads and jalr
        endcase

        case (opcode)
            rvIsaPkg::opR, rvIsaPkg::opI, rvIsaPkg::opLoad,
            rvIsaPkg::opJal, rvIsaPkg::opJalr,
            rvIsaPkg::opLui, rvIsaPkg::opAuipc: regWrite = 1'b1;
            default:                            regWrite = 1'b0;  // stores, branches
        endcase

        pcSrc = rvCtrlPkg::pcSelPlus4;              // not-taken default
        case (opcode)
            rvIsaPkg::opBranch: begin
                case (funct3)
                    rvIsaPkg::f3Beq:  if (zeroFlag)      pcSrc = rvCtrlPkg::pcSelTarget;
                    rvIsaPkg::f3Bne:  if (!zeroFlag)     pcSrc = rvCtrlPkg::pcSelTarget;
                    rvIsaPkg::f3Blt:  if (negativeFlag)  pcSrc = rvCtrlPkg::pcSelTarget;
                    rvIsaPkg::f3Bge:  if (!negativeFlag) pcSrc = rvCtrlPkg::pcSelTarget;
                    rvIsaPkg::f3Bltu: if (unsignedLess)  pcSrc = rvCtrlPkg::pcSelTarget;
                    rvIsaPkg::f3Bgeu: if (!unsignedLess) pcSrc = rvCtrlPkg::pcSelTarget;
                    default:          pcSrc = rvCtrlPkg::pcSelPlus4;  // reserved funct3
                endcase
            end
            rvIsaPkg::opJalr: pcSrc = rvCtrlPkg::pcSelAlu;
            rvIsaPkg::opJal:  pcSrc = rvCtrlPkg::pcSelTarget;
            default:          pcSrc = rvCtrlPkg::pcSelPlus4;
        endcase
    end

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`default_nettype none

module fetchStage #(
    parameter logic [rvIsaPkg::xlen-1:0] resetPc = '0    // first fetch address
) (
    input  logic clk,
    input  logic rstN,
    pcIf.fetch   pcBus
);

    logic [rvIsaPkg::xlen-1:0] pcNext;                  // d input of the pc register

    assign pcBus.pcPlus4 = pcBus.pc + rvIsaPkg::xlen'(4); // sequential successor

    always_comb begin
        case (pcBus.pcSrc)
            rvCtrlPkg::pcSelTarget: pcNext = pcBus.pcTarget;   // branch taken or jal
            rvCtrlPkg::pcSelAlu:    pcNext = pcBus.aluResult;  // jalr
            default:                pcNext = pcBus.pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcBus.pc <= resetPc;                        // held here during reset
        end else begin
            pcBus.pc <= pcNext;                         // one instruction per cycle
        end
    end

    // a jalr base with bit 1 set or a bad offset would break alignment
    pcWordAligned: assert property (
        @(posedge clk) disable iff (!rstN) pcBus.pc[1:0] == 2'b00
    ) else $error("pc %h is not word aligned", pcBus.pc);

endmodule

`default_nettype wire

/* design/rvCoreIf.sv */
`default_nettype none

// next-pc selection between the execute and fetch stages
interface pcIf;
    rvCtrlPkg::pcSrcT          pcSrc;
    logic [rvIsaPkg::xlen-1:0] pcTarget;    // pc + imm
    logic [rvIsaPkg::xlen-1:0] aluResult;   // jalr target, bit 0 already cleared
    logic [rvIsaPkg::xlen-1:0] pc;
    logic [rvIsaPkg::xlen-1:0] pcPlus4;

    modport fetch (input pcSrc, pcTarget, aluResult, output pc, pcPlus4);
    modport exec  (output pcSrc, pcTarget, aluResult, input pc, pcPlus4);
endinterface

// memory access and writeback between the execute and memory stages
interface memIf;
    logic [rvIsaPkg::xlen-1:0] aluResult;   // address or alu value
    logic [rvIsaPkg::xlen-1:0] writeData;   // rs2 for stores
    logic                      memWrite;
    rvCtrlPkg::resultSrcT      resultSrc;
    logic [2:0]                funct3;      // access size
    logic [rvIsaPkg::xlen-1:0] pcPlus4;
    logic [rvIsaPkg::xlen-1:0] pcTarget;
    logic [rvIsaPkg::xlen-1:0] result;      // writeback value

    modport exec (output aluResult, writeData, memWrite, resultSrc, funct3, pcPlus4, pcTarget,
                  input result);
    modport mem  (input aluResult, writeData, memWrite, resultSrc, funct3, pcPlus4, pcTarget,
                  output result);
endinterface

`default_nettype wire

/* design/rvCtrlPkg.sv */
`default_nettype none

package rvCtrlPkg;

    typedef enum logic [2:0] {
        aluOpR      = 3'b000,
        aluOpI      = 3'b001,
        aluOpLoad   = 3'b010,
        aluOpStore  = 3'b011,
        aluOpBranch = 3'b100,
        aluOpJump   = 3'b101,       // jal and jalr share this class
        aluOpLui    = 3'b110,
        aluOpAuipc  = 3'b111
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu      = 2'b00,
        resLoad     = 2'b01,
        resPcPlus4  = 2'b10,        // link value of jal and jalr
        resPcTarget = 2'b11         // auipc
    } resultSrcT;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSrcT;

    typedef enum logic [1:0] {
        pcSelPlus4  = 2'b00,
        pcSelTarget = 2'b01,        // taken branch or jal
        pcSelAlu    = 2'b11         // jalr
    } pcSrcT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluCtrlT;

endpackage

`default_nettype wire

/* design/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    localparam int xlen     = 32;                       // data word width
    localparam int opcodeW  = 7;                        // instr[6:0]
    localparam int funct3W  = 3;                        // instr[14:12]
    localparam int regAddrW = 5;                        // rs1, rs2, rd fields

    typedef logic [regAddrW-1:0] regAddrT;              // x0 .. x31

    // major opcodes of the supported subset
    localparam logic [opcodeW-1:0] opR      = 7'b0110011;  // reg-reg alu
    localparam logic [opcodeW-1:0] opI      = 7'b0010011;  // reg-imm alu
    localparam logic [opcodeW-1:0] opLoad   = 7'b0000011;
    localparam logic [opcodeW-1:0] opStore  = 7'b0100011;
    localparam logic [opcodeW-1:0] opBranch = 7'b1100011;
    localparam logic [opcodeW-1:0] opJal    = 7'b1101111;
    localparam logic [opcodeW-1:0] opJalr   = 7'b1100111;
    localparam logic [opcodeW-1:0] opLui    = 7'b0110111;
    localparam logic [opcodeW-1:0] opAuipc  = 7'b0010111;

    localparam logic [funct3W-1:0] f3Beq    = 3'b000;      // branch conditions
    localparam logic [funct3W-1:0] f3Bne    = 3'b001;
    localparam logic [funct3W-1:0] f3Blt    = 3'b100;
    localparam logic [funct3W-1:0] f3Bge    = 3'b101;
    localparam logic [funct3W-1:0] f3Bltu   = 3'b110;
    localparam logic [funct3W-1:0] f3Bgeu   = 3'b111;

    localparam logic [funct3W-1:0] f3Byte   = 3'b000;      // load and store sizes
    localparam logic [funct3W-1:0] f3Half   = 3'b001;
    localparam logic [funct3W-1:0] f3Word   = 3'b010;
    localparam logic [funct3W-1:0] f3ByteU  = 3'b100;      // loads only
    localparam logic [funct3W-1:0] f3HalfU  = 3'b101;

endpackage

`default_nettype wire
